//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_token_engine
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- glb_arbiter.sv
// fixed priority op, wl, if; one GLB access per cycle, read data returns the following cycle
`timescale 1ns/1ns
`default_nettype none

module glb_arbiter import token_pkg::*; (
    input  logic             clk,
    input  logic             arst_n_i,
    glb_port_if.arbiter      op_port,
    glb_port_if.arbiter      wl_port,
    glb_port_if.arbiter      if_port,
    output logic             glb_re_o,
    output logic [WEB_W-1:0] glb_web_o,
    output glb_addr_t        glb_addr_o,
    output glb_word_t        glb_wdata_o,
    input  glb_word_t        glb_rdata_i
);

    logic op_gnt;
    logic wl_gnt;
    logic if_gnt;
    logic sel_write;
    logic op_rd_q;  // reader tag, one bit per client
    logic wl_rd_q;
    logic if_rd_q;

    assign op_gnt = op_port.req;
    assign wl_gnt = wl_port.req && !op_port.req;
    assign if_gnt = if_port.req && !op_port.req && !wl_port.req;

    assign op_port.gnt = op_gnt;
    assign wl_port.gnt = wl_gnt;
    assign if_port.gnt = if_gnt;

    always_comb begin
        sel_write   = 1'b0;
        glb_addr_o  = '0;
        glb_wdata_o = '0;
        if (op_gnt) begin
            sel_write   = op_port.write;
            glb_addr_o  = op_port.addr;
            glb_wdata_o = op_port.wdata;
        end else if (wl_gnt) begin
            sel_write   = wl_port.write;
            glb_addr_o  = wl_port.addr;
            glb_wdata_o = wl_port.wdata;
        end else if (if_gnt) begin
            sel_write   = if_port.write;
            glb_addr_o  = if_port.addr;
            glb_wdata_o = if_port.wdata;
        end
    end

    assign glb_re_o  = (op_gnt || wl_gnt || if_gnt) && !sel_write;
    assign glb_web_o = ((op_gnt || wl_gnt || if_gnt) && sel_write) ? WEB_ALL : '0;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            op_rd_q <= 1'b0;
            wl_rd_q <= 1'b0;
            if_rd_q <= 1'b0;
        end else begin
            op_rd_q <= op_gnt && !op_port.write;
            wl_rd_q <= wl_gnt && !wl_port.write;
            if_rd_q <= if_gnt && !if_port.write;
        end
    end

    // rdata is shared, rvalid tells each client whose word it is
    assign op_port.rvalid = op_rd_q;
    assign wl_port.rvalid = wl_rd_q;
    assign if_port.rvalid = if_rd_q;
    assign op_port.rdata  = glb_rdata_i;
    assign wl_port.rdata  = glb_rdata_i;
    assign if_port.rdata  = glb_rdata_i;

endmodule

`default_nettype wire

//--- glb_port_if.sv
// one GLB client link; gnt is combinational, rdata and rvalid come the cycle after a read gnt
`timescale 1ns/1ns
`default_nettype none

interface glb_port_if import token_pkg::*; ();

    logic      req;
    logic      write;   // 0 read, 1 full-word write
    glb_addr_t addr;
    glb_word_t wdata;
    logic      gnt;
    logic      rvalid;
    glb_word_t rdata;

    modport client (
        output req, write, addr, wdata,
        input  gnt, rvalid, rdata
    );

    modport arbiter (
        input  req, write, addr, wdata,
        output gnt, rvalid, rdata
    );

endinterface

`default_nettype wire

//--- ifmap_fetcher.sv
// fetches in_c_i words per lane, lane-major, one read in flight; stalls while the lane is full
`timescale 1ns/1ns
`default_nettype none

module ifmap_fetcher import token_pkg::*; #(
    parameter int NUM_LANES = 4
) (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 start_i,
    input  glb_addr_t            ifmap_base_i,
    input  dim_t                 in_c_i,
    input  logic [NUM_LANES-1:0] ifmap_full_i,
    glb_port_if.client           port,
    output logic [NUM_LANES-1:0] push_o,
    output glb_word_t            push_data_o,
    output logic                 done_o
);

    localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
    localparam logic [NUM_LANES-1:0] LANE0 = 1;

    logic              active_q;
    logic              pending_q;  // read granted, data not back yet
    logic [LANE_W-1:0] lane_q;
    dim_t              word_q;
    logic              last_word;
    logic              last_lane;
    glb_addr_t         word_idx;

    assign word_idx  = glb_addr_t'(lane_q) * glb_addr_t'(in_c_i) + glb_addr_t'(word_q);
    assign last_word = (word_q == in_c_i - dim_t'(1));
    assign last_lane = (lane_q == LANE_W'(NUM_LANES - 1));

    assign port.req   = active_q && !pending_q && !ifmap_full_i[lane_q];
    assign port.write = 1'b0;
    assign port.addr  = ifmap_base_i + word_idx * glb_addr_t'(WORD_BYTES);
    assign port.wdata = '0;

    // returned word goes straight into the lane that asked for it
    assign push_o      = port.rvalid ? (LANE0 << lane_q) : '0;
    assign push_data_o = port.rdata;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            active_q  <= 1'b0;
            pending_q <= 1'b0;
            lane_q    <= '0;
            word_q    <= '0;
            done_o    <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                active_q  <= (in_c_i != '0);
                done_o    <= (in_c_i == '0);  // nothing to fetch
                pending_q <= 1'b0;
                lane_q    <= '0;
                word_q    <= '0;
            end else if (port.gnt) begin
                pending_q <= 1'b1;
            end else if (port.rvalid) begin
                pending_q <= 1'b0;
                if (!last_word) begin
                    word_q <= word_q + dim_t'(1);
                end else begin
                    word_q <= '0;
                    if (last_lane) begin
                        active_q <= 1'b0;
                        done_o   <= 1'b1;
                    end else begin
                        lane_q <= lane_q + LANE_W'(1);
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- opsum_drainer.sv
// writes out_c_i words per lane back to GLB, lane-major; opsum FIFOs must be first-word-fall-through
`timescale 1ns/1ns
`default_nettype none

module opsum_drainer import token_pkg::*; #(
    parameter int NUM_LANES = 4
) (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 start_i,
    input  glb_addr_t            opsum_base_i,
    input  dim_t                 out_c_i,
    input  logic [NUM_LANES-1:0] opsum_empty_i,
    input  glb_word_t            opsum_pop_data_i [NUM_LANES],
    glb_port_if.client           port,
    output logic [NUM_LANES-1:0] pop_o,
    output logic                 done_o
);

    localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
    localparam logic [NUM_LANES-1:0] LANE0 = 1;

    logic              active_q;
    logic [LANE_W-1:0] lane_q;
    dim_t              word_q;
    logic              last_word;
    logic              last_lane;
    glb_addr_t         word_idx;

    assign word_idx  = glb_addr_t'(lane_q) * glb_addr_t'(out_c_i) + glb_addr_t'(word_q);
    assign last_word = (word_q == out_c_i - dim_t'(1));
    assign last_lane = (lane_q == LANE_W'(NUM_LANES - 1));

    assign port.req   = active_q && !opsum_empty_i[lane_q];
    assign port.write = 1'b1;
    assign port.addr  = opsum_base_i + word_idx * glb_addr_t'(WORD_BYTES);
    assign port.wdata = opsum_pop_data_i[lane_q];  // head of the current lane

    assign pop_o = port.gnt ? (LANE0 << lane_q) : '0;  // write and pop in one cycle

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            active_q <= 1'b0;
            lane_q   <= '0;
            word_q   <= '0;
            done_o   <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                active_q <= (out_c_i != '0);
                done_o   <= (out_c_i == '0);
                lane_q   <= '0;
                word_q   <= '0;
            end else if (port.gnt) begin
                if (!last_word) begin
                    word_q <= word_q + dim_t'(1);
                end else begin
                    word_q <= '0;
                    if (last_lane) begin
                        active_q <= 1'b0;
                        done_o   <= 1'b1;
                    end else begin
                        lane_q <= lane_q + LANE_W'(1);
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- pass_sequencer.sv
// pass control; ignores pass_start_i while a pass runs, done inputs must be single-cycle pulses
`timescale 1ns/1ns
`default_nettype none

module pass_sequencer import token_pkg::*; (
    input  logic clk,
    input  logic arst_n_i,
    input  logic pass_start_i,
    input  logic wl_done_i,
    input  logic fetch_done_i,
    input  logic drain_done_i,
    output logic wl_start_o,
    output logic compute_start_o,
    output logic fifo_reset_o,
    output logic pe_en_o,
    output logic pass_done_o
);

    pass_state_t state_q;
    pass_state_t state_d;
    logic        fetch_seen_q;
    logic        drain_seen_q;
    logic        fetch_ok;
    logic        drain_ok;

    // done pulses may arrive in either order, or together
    assign fetch_ok = fetch_seen_q || fetch_done_i;
    assign drain_ok = drain_seen_q || drain_done_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:     if (pass_start_i) state_d = WEIGHT;
            WEIGHT:   if (wl_done_i) state_d = FIFO_RST;
            FIFO_RST: state_d = COMPUTE;  // single cycle
            COMPUTE:  if (fetch_ok && drain_ok) state_d = DONE;
            DONE:     state_d = IDLE;
            default:  state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q         <= IDLE;
            wl_start_o      <= 1'b0;
            compute_start_o <= 1'b0;
            fetch_seen_q    <= 1'b0;
            drain_seen_q    <= 1'b0;
        end else begin
            state_q         <= state_d;
            wl_start_o      <= (state_q == IDLE) && pass_start_i;
            compute_start_o <= (state_q == FIFO_RST);
            if (state_q == FIFO_RST) begin
                fetch_seen_q <= 1'b0;
                drain_seen_q <= 1'b0;
            end else begin
                fetch_seen_q <= fetch_ok;
                drain_seen_q <= drain_ok;
            end
        end
    end

    assign fifo_reset_o = (state_q == FIFO_RST);
    assign pe_en_o      = (state_q == COMPUTE);
    assign pass_done_o  = (state_q == DONE);

endmodule

`default_nettype wire

//--- sources.f
token_pkg.sv
glb_port_if.sv
pass_sequencer.sv
weight_loader.sv
ifmap_fetcher.sv
opsum_drainer.sv
glb_arbiter.sv
token_engine.sv
tb_token_engine.sv

//--- tb_token_engine.sv
// testbench for token_engine; GLB and FIFO models are behavioral, passes use disjoint regions
`timescale 1ns/1ns
`default_nettype none

module tb_token_engine import token_pkg::*; ();

    localparam int NUM_LANES    = 4;
    localparam int PASS_TIMEOUT = 2000;  // cycles per pass
    localparam logic [NUM_LANES-1:0] LANE_ONE = 1;

    logic                 clk;
    logic                 arst_n_i;
    logic                 pass_start_i;
    logic                 pass_done_o;
    glb_addr_t            weight_base_i;
    glb_addr_t            ifmap_base_i;
    glb_addr_t            opsum_base_i;
    dim_t                 in_c_i;
    dim_t                 out_c_i;
    logic                 glb_re_o;
    logic [WEB_W-1:0]     glb_web_o;
    glb_addr_t            glb_addr_o;
    glb_word_t            glb_wdata_o;
    glb_word_t            glb_rdata_i = '0;
    logic [7:0]           weight_in_o;
    logic [NUM_LANES-1:0] weight_load_en_o;
    logic                 pe_en_o;
    logic                 fifo_reset_o;
    logic [NUM_LANES-1:0] ifmap_push_o;
    glb_word_t            ifmap_push_data_o;
    logic [NUM_LANES-1:0] ifmap_full_i = '0;
    logic [NUM_LANES-1:0] opsum_pop_o;
    logic [NUM_LANES-1:0] opsum_empty_i = '1;
    glb_word_t            opsum_pop_data_i [NUM_LANES] = '{default: '0};

    // models and scoreboard state
    int        seed = 56;
    glb_word_t mem [glb_addr_t];
    glb_word_t op_q [NUM_LANES][$];
    int        wl_cnt = 0;
    int        push_total = 0;
    int        push_cnt [NUM_LANES] = '{default: 0};
    int        wr_total = 0;
    int        wr_cnt [NUM_LANES] = '{default: 0};
    int        rst_cnt = 0;
    int        done_cnt = 0;
    logic      in_compute = 1'b0;
    int        check_errors = 0;
    int        timeout_errors = 0;

    // expected values for the coming edge
    logic [NUM_LANES-1:0] exp_wl_en = '0;
    logic [7:0]           exp_weight = '0;
    logic [NUM_LANES-1:0] exp_push = '0;
    glb_word_t            exp_push_data = '0;
    logic [NUM_LANES-1:0] exp_pop = '0;
    glb_addr_t            exp_wr_addr = '0;
    glb_word_t            exp_wr_data = '0;
    logic                 if_rd_blocked = 1'b0;

    token_engine #(.NUM_LANES(NUM_LANES)) token_engine_inst (
        .clk               (clk),
        .arst_n_i          (arst_n_i),
        .pass_start_i      (pass_start_i),
        .pass_done_o       (pass_done_o),
        .weight_base_i     (weight_base_i),
        .ifmap_base_i      (ifmap_base_i),
        .opsum_base_i      (opsum_base_i),
        .in_c_i            (in_c_i),
        .out_c_i           (out_c_i),
        .glb_re_o          (glb_re_o),
        .glb_web_o         (glb_web_o),
        .glb_addr_o        (glb_addr_o),
        .glb_wdata_o       (glb_wdata_o),
        .glb_rdata_i       (glb_rdata_i),
        .weight_in_o       (weight_in_o),
        .weight_load_en_o  (weight_load_en_o),
        .pe_en_o           (pe_en_o),
        .fifo_reset_o      (fifo_reset_o),
        .ifmap_push_o      (ifmap_push_o),
        .ifmap_push_data_o (ifmap_push_data_o),
        .ifmap_full_i      (ifmap_full_i),
        .opsum_pop_o       (opsum_pop_o),
        .opsum_empty_i     (opsum_empty_i),
        .opsum_pop_data_i  (opsum_pop_data_i)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic note_failure(input string msg);
        check_errors++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
    endtask

    // ~a stands in for a word the DUT never read
    function automatic glb_word_t mem_word(input glb_addr_t a);
        if (mem.exists(a)) return mem[a];
        return ~a;
    endfunction

    // sample DUT outputs on the edge, update models 1 ns later
    always @(posedge clk) begin
        logic                 start_s;
        logic                 rst_s;
        logic                 done_s;
        logic                 re_s;
        logic [WEB_W-1:0]     web_s;
        glb_addr_t            addr_s;
        glb_word_t            wdata_s;
        logic [NUM_LANES-1:0] wl_s;
        logic [NUM_LANES-1:0] push_s;
        logic [NUM_LANES-1:0] pop_s;
        start_s = pass_start_i;
        rst_s   = fifo_reset_o;
        done_s  = pass_done_o;
        re_s    = glb_re_o;
        web_s   = glb_web_o;
        addr_s  = glb_addr_o;
        wdata_s = glb_wdata_o;
        wl_s    = weight_load_en_o;
        push_s  = ifmap_push_o;
        pop_s   = opsum_pop_o;
        #1;
        if (start_s) begin
            wl_cnt     = 0;
            push_total = 0;
            wr_total   = 0;
            rst_cnt    = 0;
            done_cnt   = 0;
            for (int l = 0; l < NUM_LANES; l++) begin
                push_cnt[l] = 0;
                wr_cnt[l]   = 0;
            end
        end
        if (wl_s != '0) wl_cnt++;
        if (push_s != '0) push_total++;
        if (pop_s != '0) wr_total++;
        for (int l = 0; l < NUM_LANES; l++) begin
            if (push_s[l]) push_cnt[l]++;
            if (pop_s[l]) begin
                wr_cnt[l]++;
                if (op_q[l].size() > 0) void'(op_q[l].pop_front());
            end
        end
        if (rst_s) begin  // PEs start producing fresh opsums
            rst_cnt++;
            in_compute = 1'b1;
            for (int l = 0; l < NUM_LANES; l++) begin
                op_q[l].delete();
                for (int k = 0; k < int'(out_c_i); k++) op_q[l].push_back($random(seed));
            end
        end
        if (done_s) begin
            done_cnt++;
            in_compute = 1'b0;
        end
        if (web_s != '0) mem[addr_s] = wdata_s;
        if (re_s) begin
            if (!mem.exists(addr_s)) mem[addr_s] = $random(seed);
            glb_rdata_i = mem[addr_s];  // one cycle read latency
        end
        for (int l = 0; l < NUM_LANES; l++) begin
            ifmap_full_i[l]     = (($random(seed) & 3) == 0);
            opsum_empty_i[l]    = (op_q[l].size() == 0) || (($random(seed) & 7) == 0);
            opsum_pop_data_i[l] = (op_q[l].size() > 0) ? op_q[l][0] : '0;
        end
    end

    // everything is settled mid-cycle
    always @(negedge clk) begin
        int        ic;
        int        oc;
        int        pl;
        int        ol;
        int        idx;
        glb_word_t wword;
        ic = int'(in_c_i);
        oc = int'(out_c_i);
        if (wl_cnt < NUM_LANES) begin
            exp_wl_en  = LANE_ONE << wl_cnt;
            wword      = mem_word(weight_base_i + glb_addr_t'(wl_cnt * WORD_BYTES));
            exp_weight = wword[7:0];
        end else begin
            exp_wl_en  = '0;
            exp_weight = '0;
        end
        pl = (ic > 0) ? push_total / ic : NUM_LANES;
        if (pl < NUM_LANES) begin
            exp_push      = LANE_ONE << pl;
            exp_push_data = mem_word(ifmap_base_i
                                     + glb_addr_t'((pl * ic + push_cnt[pl]) * WORD_BYTES));
        end else begin
            exp_push      = '0;  // no push expected any more
            exp_push_data = '0;
        end
        ol = (oc > 0) ? wr_total / oc : NUM_LANES;
        if (ol < NUM_LANES) begin
            exp_pop     = LANE_ONE << ol;
            exp_wr_addr = opsum_base_i + glb_addr_t'((ol * oc + wr_cnt[ol]) * WORD_BYTES);
            exp_wr_data = (op_q[ol].size() > 0) ? op_q[ol][0] : '0;
        end else begin
            exp_pop     = '0;
            exp_wr_addr = '0;
            exp_wr_data = '0;
        end
        if_rd_blocked = 1'b0;
        if (glb_re_o && ic > 0 && glb_addr_o >= ifmap_base_i) begin
            idx = int'((glb_addr_o - ifmap_base_i) / glb_addr_t'(WORD_BYTES));
            if (idx < NUM_LANES * ic) if_rd_blocked = ifmap_full_i[idx / ic];
        end
    end

    a_weight: assert property (@(posedge clk) disable iff (!arst_n_i)
        (weight_load_en_o != '0) |-> (weight_load_en_o == exp_wl_en && weight_in_o == exp_weight))
        else note_failure("weight row enable or weight byte wrong");

    a_push: assert property (@(posedge clk) disable iff (!arst_n_i)
        (ifmap_push_o != '0) |-> (ifmap_push_o == exp_push && ifmap_push_data_o == exp_push_data))
        else note_failure("ifmap push lane or data wrong");

    a_read_full: assert property (@(posedge clk) disable iff (!arst_n_i) !if_rd_blocked)
        else note_failure("ifmap read issued for a full lane");

    a_write: assert property (@(posedge clk) disable iff (!arst_n_i)
        (glb_web_o != '0) |-> (glb_web_o == WEB_ALL && glb_addr_o == exp_wr_addr
                               && glb_wdata_o == exp_wr_data && opsum_pop_o == exp_pop))
        else note_failure("opsum write address, data, enable or pop wrong");

    a_pop: assert property (@(posedge clk) disable iff (!arst_n_i)
        (opsum_pop_o != '0) |-> (glb_web_o != '0))
        else note_failure("opsum pop without a write");

    a_pop_empty: assert property (@(posedge clk) disable iff (!arst_n_i)
        (opsum_pop_o & opsum_empty_i) == '0)
        else note_failure("opsum pop from an empty lane");

    a_port: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(glb_re_o && glb_web_o != '0))
        else note_failure("read and write on the GLB port in one cycle");

    a_fifo_rst: assert property (@(posedge clk) disable iff (!arst_n_i)
        fifo_reset_o |-> (wl_cnt == NUM_LANES && push_total == 0 && rst_cnt == 0))
        else note_failure("fifo_reset_o out of order or repeated");

    a_pe_on: assert property (@(posedge clk) disable iff (!arst_n_i)
        (in_compute && !pass_done_o) |-> pe_en_o)
        else note_failure("pe_en_o low during compute");

    a_pe_off: assert property (@(posedge clk) disable iff (!arst_n_i) pe_en_o |-> in_compute)
        else note_failure("pe_en_o high outside compute");

    a_done: assert property (@(posedge clk) disable iff (!arst_n_i)
        pass_done_o |-> (done_cnt == 0 && push_total == NUM_LANES * int'(in_c_i)
                         && wr_total == NUM_LANES * int'(out_c_i)))
        else note_failure("pass_done_o early or repeated");

    task automatic run_pass(input glb_addr_t wb, input glb_addr_t ib, input glb_addr_t ob,
                            input dim_t ic, input dim_t oc);
        int cycles;
        @(posedge clk);
        #1;
        weight_base_i = wb;
        ifmap_base_i  = ib;
        opsum_base_i  = ob;
        in_c_i        = ic;
        out_c_i       = oc;
        pass_start_i  = 1'b1;
        @(posedge clk);
        #1;
        pass_start_i = 1'b0;
        cycles = 0;
        while (!pass_done_o && cycles < PASS_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!pass_done_o) begin
            timeout_errors++;
            $display("timeout: pass_done_o did not pulse within %0d cycles", PASS_TIMEOUT);
        end
        repeat (2) @(posedge clk);
        #1;
        assert (done_cnt == 1) else note_failure("pass_done_o did not pulse exactly once");
    endtask

    initial begin
        arst_n_i      = 1'b0;
        pass_start_i  = 1'b0;
        weight_base_i = '0;
        ifmap_base_i  = '0;
        opsum_base_i  = '0;
        in_c_i        = '0;
        out_c_i       = '0;
        repeat (2) @(posedge clk);
        #1;
        arst_n_i = 1'b1;
        run_pass(32'h0000_1000, 32'h0000_2000, 32'h0000_8000, 8'd3, 8'd2);
        run_pass(32'h0001_0040, 32'h0001_4000, 32'h0002_0000, 8'd5, 8'd7);
        repeat (4) @(posedge clk);  // catch stray done pulses
        $display("errors: %0d failed checks, %0d timeouts", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- token_engine.sv
// one 3x3 conv pass; counts and base addresses must stay stable from pass_start_i to pass_done_o
`timescale 1ns/1ns
`default_nettype none

module token_engine import token_pkg::*; #(
    parameter int NUM_LANES = 4
) (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 pass_start_i,
    output logic                 pass_done_o,
    input  glb_addr_t            weight_base_i,
    input  glb_addr_t            ifmap_base_i,
    input  glb_addr_t            opsum_base_i,
    input  dim_t                 in_c_i,
    input  dim_t                 out_c_i,
    output logic                 glb_re_o,
    output logic [WEB_W-1:0]     glb_web_o,
    output glb_addr_t            glb_addr_o,
    output glb_word_t            glb_wdata_o,
    input  glb_word_t            glb_rdata_i,
    output logic [7:0]           weight_in_o,
    output logic [NUM_LANES-1:0] weight_load_en_o,
    output logic                 pe_en_o,
    output logic                 fifo_reset_o,
    output logic [NUM_LANES-1:0] ifmap_push_o,
    output glb_word_t            ifmap_push_data_o,
    input  logic [NUM_LANES-1:0] ifmap_full_i,
    output logic [NUM_LANES-1:0] opsum_pop_o,
    input  logic [NUM_LANES-1:0] opsum_empty_i,
    input  glb_word_t            opsum_pop_data_i [NUM_LANES]
);

    logic wl_start;
    logic compute_start;
    logic wl_done;
    logic fetch_done;
    logic drain_done;

    glb_port_if wl_port ();
    glb_port_if if_port ();
    glb_port_if op_port ();

    pass_sequencer pass_sequencer_inst (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .pass_start_i    (pass_start_i),
        .wl_done_i       (wl_done),
        .fetch_done_i    (fetch_done),
        .drain_done_i    (drain_done),
        .wl_start_o      (wl_start),
        .compute_start_o (compute_start),
        .fifo_reset_o    (fifo_reset_o),
        .pe_en_o         (pe_en_o),
        .pass_done_o     (pass_done_o)
    );

    weight_loader #(.NUM_LANES(NUM_LANES)) weight_loader_inst (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .start_i          (wl_start),
        .weight_base_i    (weight_base_i),
        .port             (wl_port.client),
        .weight_in_o      (weight_in_o),
        .weight_load_en_o (weight_load_en_o),
        .done_o           (wl_done)
    );

    // fetch and drain both start on compute_start and run side by side
    ifmap_fetcher #(.NUM_LANES(NUM_LANES)) ifmap_fetcher_inst (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .start_i      (compute_start),
        .ifmap_base_i (ifmap_base_i),
        .in_c_i       (in_c_i),
        .ifmap_full_i (ifmap_full_i),
        .port         (if_port.client),
        .push_o       (ifmap_push_o),
        .push_data_o  (ifmap_push_data_o),
        .done_o       (fetch_done)
    );

    opsum_drainer #(.NUM_LANES(NUM_LANES)) opsum_drainer_inst (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .start_i          (compute_start),
        .opsum_base_i     (opsum_base_i),
        .out_c_i          (out_c_i),
        .opsum_empty_i    (opsum_empty_i),
        .opsum_pop_data_i (opsum_pop_data_i),
        .port             (op_port.client),
        .pop_o            (opsum_pop_o),
        .done_o           (drain_done)
    );

    glb_arbiter glb_arbiter_inst (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .op_port     (op_port.arbiter),
        .wl_port     (wl_port.arbiter),
        .if_port     (if_port.arbiter),
        .glb_re_o    (glb_re_o),
        .glb_web_o   (glb_web_o),
        .glb_addr_o  (glb_addr_o),
        .glb_wdata_o (glb_wdata_o),
        .glb_rdata_i (glb_rdata_i)
    );

endmodule

`default_nettype wire

//--- token_pkg.sv
// shared GLB types and pass states; byte addresses step by WORD_BYTES and writes are full-word
`default_nettype none

package token_pkg;

    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int WEB_W      = DATA_W / 8;  // one enable bit per byte
    localparam int WORD_BYTES = 4;

    localparam logic [WEB_W-1:0] WEB_ALL = '1;

    typedef logic [DATA_W-1:0] glb_word_t;
    typedef logic [ADDR_W-1:0] glb_addr_t;

    // channel count, up to 255 words per lane
    typedef logic [7:0] dim_t;

    typedef enum logic [2:0] {
        IDLE,
        WEIGHT,
        FIFO_RST,
        COMPUTE,
        DONE
    } pass_state_t;

endpackage

`default_nettype wire

//--- weight_loader.sv
// loads one weight per PE row from consecutive GLB words; only the low byte of each word is used
`timescale 1ns/1ns
`default_nettype none

module weight_loader import token_pkg::*; #(
    parameter int NUM_LANES = 4
) (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 start_i,
    input  glb_addr_t            weight_base_i,
    glb_port_if.client           port,
    output logic [7:0]           weight_in_o,
    output logic [NUM_LANES-1:0] weight_load_en_o,
    output logic                 done_o
);

    localparam int CNT_W = $clog2(NUM_LANES + 1);
    localparam logic [NUM_LANES-1:0] ROW0 = 1;

    logic             active_q;
    logic [CNT_W-1:0] req_cnt_q;  // reads granted so far
    logic [CNT_W-1:0] rsp_cnt_q;  // words returned so far
    logic             last_rsp;

    // reads may be back to back, the arbiter keeps their order
    assign port.req   = active_q && (req_cnt_q < CNT_W'(NUM_LANES));
    assign port.write = 1'b0;
    assign port.addr  = weight_base_i + glb_addr_t'(req_cnt_q) * glb_addr_t'(WORD_BYTES);
    assign port.wdata = '0;

    assign weight_in_o      = port.rdata[7:0];
    assign weight_load_en_o = port.rvalid ? (ROW0 << rsp_cnt_q) : '0;
    assign last_rsp         = port.rvalid && (rsp_cnt_q == CNT_W'(NUM_LANES - 1));

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            active_q  <= 1'b0;
            req_cnt_q <= '0;
            rsp_cnt_q <= '0;
            done_o    <= 1'b0;
        end else begin
            done_o <= last_rsp;  // one cycle after the last row
            if (start_i) begin
                active_q  <= 1'b1;
                req_cnt_q <= '0;
                rsp_cnt_q <= '0;
            end else begin
                if (port.gnt) req_cnt_q <= req_cnt_q + CNT_W'(1);
                if (port.rvalid) rsp_cnt_q <= rsp_cnt_q + CNT_W'(1);
                if (last_rsp) active_q <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire
